//--- rv64_decode_pkg.sv
// shared decode types; covers the rv64im subset only, MEM_UW is defined but no decoded load yields it
package rv64_decode_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one word, six format views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_word_u;

  typedef struct packed {
    logic [63:0] imm;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rd;
    logic [2:0]  branch;
    logic        alu_a_src; // 1 = pc
    logic [1:0]  alu_b_src; // 0 rs2, 1 imm, 2 const 4
    logic [3:0]  alu_ctr;
    logic        word_cut;
    logic        reg_wr;
    logic        mem_to_reg;
    logic        mem_wr;
    logic [2:0]  mem_op;
  } decode_ctrl_t;

  localparam logic [3:0] ALU_ADD      = 4'd0;
  localparam logic [3:0] ALU_SLL      = 4'd1;
  localparam logic [3:0] ALU_COPY_IMM = 4'd3;
  localparam logic [3:0] ALU_XOR      = 4'd4;
  localparam logic [3:0] ALU_SRL      = 4'd5;
  localparam logic [3:0] ALU_OR       = 4'd6;
  localparam logic [3:0] ALU_AND      = 4'd7;
  localparam logic [3:0] ALU_SUB      = 4'd8;
  localparam logic [3:0] ALU_SLTU     = 4'd10;
  localparam logic [3:0] ALU_DIV      = 4'd11;
  localparam logic [3:0] ALU_MUL      = 4'd12;
  localparam logic [3:0] ALU_REM      = 4'd13;
  localparam logic [3:0] ALU_EBREAK   = 4'd14;
  localparam logic [3:0] ALU_INVALID  = 4'd15;

  localparam logic [2:0] MEM_SB   = 3'd0;
  localparam logic [2:0] MEM_UB   = 3'd1;
  localparam logic [2:0] MEM_SH   = 3'd2;
  localparam logic [2:0] MEM_UH   = 3'd3;
  localparam logic [2:0] MEM_SW   = 3'd4;
  localparam logic [2:0] MEM_UW   = 3'd5; // reserved, lwu not decoded
  localparam logic [2:0] MEM_SD   = 3'd6;
  localparam logic [2:0] MEM_NONE = 3'd7;

  localparam logic [2:0] BR_NONE = 3'd0;
  localparam logic [2:0] BR_JAL  = 3'd1;
  localparam logic [2:0] BR_JALR = 3'd2;
  localparam logic [2:0] BR_EQ   = 3'd4;
  localparam logic [2:0] BR_NE   = 3'd5;
  localparam logic [2:0] BR_LT   = 3'd6; // also bltu
  localparam logic [2:0] BR_GE   = 3'd7; // also bgeu

endpackage

//--- fetch_packet_reg.sv
// input register for one fetch packet; lane 0 sits in the low word, no back-pressure, payload not reset
module fetch_packet_reg #(
  parameter int NUM_LANES = 2
) (
  input  logic                                        i_clk,
  input  logic                                        i_rst_n,
  input  logic                                        i_valid,
  input  logic [NUM_LANES*32-1:0]                     i_packet,
  output logic                                        o_lane_valid,
  output rv64_decode_pkg::inst_word_u [NUM_LANES-1:0] o_lane_inst
);

  // strobe follows input every cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_lane_valid <= 1'b0;
    end else begin
      o_lane_valid <= i_valid;
    end
  end

  // packet only moves on a strobe
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        o_lane_inst[l] <= i_packet[l*32 +: 32]; // word lands in union view
      end
    end
  end

endmodule

//--- inst_decoder.sv
// combinational rv64im subset decoder; words outside the subset give ALU_INVALID, i_clk only samples the check
module inst_decoder (
  input  logic                          i_clk,
  input  rv64_decode_pkg::inst_word_u   i_inst,
  output rv64_decode_pkg::decode_ctrl_t o_ctrl
);

  wire [6:0] opcode = i_inst.r_fmt.opcode;
  wire [2:0] funct3 = i_inst.r_fmt.funct3;
  wire [6:0] funct7 = i_inst.r_fmt.funct7;

  wire op_lui    = (opcode == 7'b0110111);
  wire op_auipc  = (opcode == 7'b0010111);
  wire op_jal    = (opcode == 7'b1101111);
  wire op_jalr   = (opcode == 7'b1100111);
  wire op_branch = (opcode == 7'b1100011);
  wire op_load   = (opcode == 7'b0000011);
  wire op_store  = (opcode == 7'b0100011);
  wire op_imm    = (opcode == 7'b0010011);
  wire op_imm32  = (opcode == 7'b0011011);
  wire op_reg    = (opcode == 7'b0110011);
  wire op_reg32  = (opcode == 7'b0111011);
  wire op_system = (opcode == 7'b1110011);

  wire f7_zero = (funct7 == 7'b0000000);
  wire f7_alt  = (funct7 == 7'b0100000);
  wire f7_mul  = (funct7 == 7'b0000001);

  wire inst_jalr   = op_jalr & (funct3 == 3'b000);
  wire inst_beq    = op_branch & (funct3 == 3'b000);
  wire inst_bne    = op_branch & (funct3 == 3'b001);
  wire inst_blt    = op_branch & (funct3 == 3'b100);
  wire inst_bge    = op_branch & (funct3 == 3'b101);
  wire inst_bltu   = op_branch & (funct3 == 3'b110);
  wire inst_bgeu   = op_branch & (funct3 == 3'b111);
  wire inst_lh     = op_load & (funct3 == 3'b001);
  wire inst_lw     = op_load & (funct3 == 3'b010);
  wire inst_ld     = op_load & (funct3 == 3'b011);
  wire inst_lbu    = op_load & (funct3 == 3'b100);
  wire inst_lhu    = op_load & (funct3 == 3'b101);
  wire inst_sb     = op_store & (funct3 == 3'b000);
  wire inst_sh     = op_store & (funct3 == 3'b001);
  wire inst_sw     = op_store & (funct3 == 3'b010);
  wire inst_sd     = op_store & (funct3 == 3'b011);
  wire inst_addi   = op_imm & (funct3 == 3'b000);
  wire inst_slli   = op_imm & (funct3 == 3'b001) & (funct7[6:1] == 6'b000000); // 6-bit shamt
  wire inst_sltiu  = op_imm & (funct3 == 3'b011);
  wire inst_xori   = op_imm & (funct3 == 3'b100);
  wire inst_srli   = op_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b000000);
  wire inst_andi   = op_imm & (funct3 == 3'b111);
  wire inst_addiw  = op_imm32 & (funct3 == 3'b000);
  wire inst_add    = op_reg & (funct3 == 3'b000) & f7_zero;
  wire inst_sub    = op_reg & (funct3 == 3'b000) & f7_alt;
  wire inst_or     = op_reg & (funct3 == 3'b110) & f7_zero;
  wire inst_mul    = op_reg & (funct3 == 3'b000) & f7_mul;
  wire inst_addw   = op_reg32 & (funct3 == 3'b000) & f7_zero;
  wire inst_subw   = op_reg32 & (funct3 == 3'b000) & f7_alt;
  wire inst_sllw   = op_reg32 & (funct3 == 3'b001) & f7_zero;
  wire inst_mulw   = op_reg32 & (funct3 == 3'b000) & f7_mul;
  wire inst_divw   = op_reg32 & (funct3 == 3'b100) & f7_mul;
  wire inst_remw   = op_reg32 & (funct3 == 3'b110) & f7_mul;
  wire inst_ebreak = op_system & (funct3 == 3'b000) & (i_inst.i_fmt.imm_11_0 == 12'h001);

  wire inst_load  = |{inst_lh, inst_lhu, inst_lw, inst_lbu, inst_ld};
  wire inst_store = |{inst_sb, inst_sh, inst_sw, inst_sd};
  wire inst_cbr   = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu};

  wire type_r = |{inst_add, inst_sub, inst_or, inst_mul, inst_addw, inst_subw,
                  inst_sllw, inst_mulw, inst_divw, inst_remw};
  wire type_i = |{inst_jalr, inst_load, inst_addi, inst_slli, inst_sltiu, inst_xori,
                  inst_srli, inst_andi, inst_addiw, inst_ebreak};
  wire type_u = op_lui | op_auipc;
  wire type_s = inst_store;
  wire type_b = inst_cbr;
  wire type_j = op_jal;

  wire [5:0] fmt_class = {type_r, type_i, type_u, type_s, type_b, type_j};

  // immediates, each from its own view
  wire [63:0] imm_i = {{52{i_inst.i_fmt.imm_11_0[11]}}, i_inst.i_fmt.imm_11_0};
  wire [63:0] imm_u = {{32{i_inst.u_fmt.imm_31_12[19]}}, i_inst.u_fmt.imm_31_12, 12'b0};
  wire [63:0] imm_s = {{52{i_inst.s_fmt.imm_11_5[6]}}, i_inst.s_fmt.imm_11_5,
                       i_inst.s_fmt.imm_4_0};
  wire [63:0] imm_b = {{52{i_inst.b_fmt.imm_12}}, i_inst.b_fmt.imm_11, i_inst.b_fmt.imm_10_5,
                       i_inst.b_fmt.imm_4_1, 1'b0};
  wire [63:0] imm_j = {{44{i_inst.j_fmt.imm_20}}, i_inst.j_fmt.imm_19_12, i_inst.j_fmt.imm_11,
                       i_inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    o_ctrl.ra = i_inst.r_fmt.rs1;
    o_ctrl.rb = i_inst.r_fmt.rs2;
    o_ctrl.rd = i_inst.r_fmt.rd;

    case (1'b1)
      type_i:  o_ctrl.imm = imm_i;
      type_u:  o_ctrl.imm = imm_u;
      type_s:  o_ctrl.imm = imm_s;
      type_b:  o_ctrl.imm = imm_b;
      type_j:  o_ctrl.imm = imm_j;
      default: o_ctrl.imm = 64'd0; // r type and unknown
    endcase

    o_ctrl.alu_a_src  = op_jal | inst_jalr | op_auipc;
    o_ctrl.alu_b_src  = {op_jal | inst_jalr, (type_i | type_u | type_s) & ~inst_jalr};
    o_ctrl.word_cut   = |{inst_addiw, inst_addw, inst_subw, inst_sllw, inst_mulw, inst_divw,
                          inst_remw};
    o_ctrl.reg_wr     = type_r | type_i | type_u | type_j;
    o_ctrl.mem_to_reg = inst_load;
    o_ctrl.mem_wr     = inst_store;

    // loads sign-extend, stores ignore the sign bit
    case (1'b1)
      inst_sb:          o_ctrl.mem_op = rv64_decode_pkg::MEM_SB;
      inst_lbu:         o_ctrl.mem_op = rv64_decode_pkg::MEM_UB;
      inst_lh, inst_sh: o_ctrl.mem_op = rv64_decode_pkg::MEM_SH;
      inst_lhu:         o_ctrl.mem_op = rv64_decode_pkg::MEM_UH;
      inst_lw, inst_sw: o_ctrl.mem_op = rv64_decode_pkg::MEM_SW;
      inst_ld, inst_sd: o_ctrl.mem_op = rv64_decode_pkg::MEM_SD;
      default:          o_ctrl.mem_op = rv64_decode_pkg::MEM_NONE;
    endcase

    case (1'b1)
      op_jal:               o_ctrl.branch = rv64_decode_pkg::BR_JAL;
      inst_jalr:            o_ctrl.branch = rv64_decode_pkg::BR_JALR;
      inst_beq:             o_ctrl.branch = rv64_decode_pkg::BR_EQ;
      inst_bne:             o_ctrl.branch = rv64_decode_pkg::BR_NE;
      inst_blt, inst_bltu:  o_ctrl.branch = rv64_decode_pkg::BR_LT;
      inst_bge, inst_bgeu:  o_ctrl.branch = rv64_decode_pkg::BR_GE;
      default:              o_ctrl.branch = rv64_decode_pkg::BR_NONE;
    endcase

    case (1'b1)
      op_lui:                                  o_ctrl.alu_ctr = rv64_decode_pkg::ALU_COPY_IMM;
      op_auipc, op_jal, inst_jalr, inst_addi,
      inst_add, inst_load, inst_store,
      inst_addiw, inst_addw:                   o_ctrl.alu_ctr = rv64_decode_pkg::ALU_ADD;
      inst_cbr, inst_sub, inst_subw:           o_ctrl.alu_ctr = rv64_decode_pkg::ALU_SUB;
      inst_sltiu:                              o_ctrl.alu_ctr = rv64_decode_pkg::ALU_SLTU;
      inst_xori:                               o_ctrl.alu_ctr = rv64_decode_pkg::ALU_XOR;
      inst_andi:                               o_ctrl.alu_ctr = rv64_decode_pkg::ALU_AND;
      inst_or:                                 o_ctrl.alu_ctr = rv64_decode_pkg::ALU_OR;
      inst_slli, inst_sllw:                    o_ctrl.alu_ctr = rv64_decode_pkg::ALU_SLL;
      inst_srli:                               o_ctrl.alu_ctr = rv64_decode_pkg::ALU_SRL;
      inst_mul, inst_mulw:                     o_ctrl.alu_ctr = rv64_decode_pkg::ALU_MUL;
      inst_divw:                               o_ctrl.alu_ctr = rv64_decode_pkg::ALU_DIV;
      inst_remw:                               o_ctrl.alu_ctr = rv64_decode_pkg::ALU_REM;
      inst_ebreak:                             o_ctrl.alu_ctr = rv64_decode_pkg::ALU_EBREAK;
      default:                                 o_ctrl.alu_ctr = rv64_decode_pkg::ALU_INVALID;
    endcase
  end

  // immediate select relies on exclusive format classes
  // known words carry exactly one class, unknown words none
  fmt_onehot_a: assert property (@(posedge i_clk)
    $onehot0(fmt_class) &&
    ((|fmt_class) == (o_ctrl.alu_ctr != rv64_decode_pkg::ALU_INVALID)))
    else $error("inst_decoder: format class does not match decode for %h", i_inst);

endmodule

//--- decode_out_reg.sv
// output register for all lane bundles; o_halt is sticky until reset, every lane of a packet counts as valid
module decode_out_reg #(
  parameter int NUM_LANES = 2
) (
  input  logic                                          i_clk,
  input  logic                                          i_rst_n,
  input  logic                                          i_lane_valid,
  input  rv64_decode_pkg::decode_ctrl_t [NUM_LANES-1:0] i_ctrl,
  output logic                                          o_valid,
  output rv64_decode_pkg::decode_ctrl_t [NUM_LANES-1:0] o_ctrl,
  output logic                                          o_halt
);

  logic halt_hit;

  // any lane carrying ebreak
  always_comb begin
    halt_hit = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      halt_hit = halt_hit | (i_ctrl[l].alu_ctr == rv64_decode_pkg::ALU_EBREAK);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
      o_ctrl  <= '0;
      o_halt  <= 1'b0;
    end else begin
      o_valid <= i_lane_valid;
      if (i_lane_valid) begin
        o_ctrl <= i_ctrl; // hold otherwise
        if (halt_hit) begin
          o_halt <= 1'b1; // rises with the carrying o_valid
        end
      end
    end
  end

  halt_sticky_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_halt |=> o_halt)
    else $error("decode_out_reg: o_halt fell without reset");

  // back-to-back outputs need back-to-back strobes upstream
  valid_pair_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && $past(o_valid)) |-> ($past(i_lane_valid) && $past(i_lane_valid, 2)))
    else $error("decode_out_reg: o_valid pair without two strobes");

endmodule

//--- decode_stage_top.sv
// decode stage with fixed 2-cycle latency from strobe to o_valid; plain valid strobes, no stall or back-pressure
module decode_stage_top #(
  parameter int NUM_LANES = 2
) (
  input  logic                                          i_clk,
  input  logic                                          i_rst_n,
  input  logic                                          i_valid,
  input  logic [NUM_LANES*32-1:0]                       i_packet,
  output logic                                          o_valid,
  output rv64_decode_pkg::decode_ctrl_t [NUM_LANES-1:0] o_ctrl,
  output logic                                          o_halt
);

  logic                                          lane_valid;
  rv64_decode_pkg::inst_word_u   [NUM_LANES-1:0] lane_inst;
  rv64_decode_pkg::decode_ctrl_t [NUM_LANES-1:0] lane_ctrl;

  fetch_packet_reg #(.NUM_LANES(NUM_LANES)) u_fetch_packet_reg (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_packet     (i_packet),
    .o_lane_valid (lane_valid),
    .o_lane_inst  (lane_inst)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    inst_decoder u_inst_decoder (
      .i_clk  (i_clk),
      .i_inst (lane_inst[g]),
      .o_ctrl (lane_ctrl[g])
    );
  end

  decode_out_reg #(.NUM_LANES(NUM_LANES)) u_decode_out_reg (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_lane_valid (lane_valid),
    .i_ctrl       (lane_ctrl),
    .o_valid      (o_valid),
    .o_ctrl       (o_ctrl),
    .o_halt       (o_halt)
  );

endmodule

//--- tb_decode_stage.sv
// needs decode_cases.txt in the working directory; a short last packet is filled from the first cases
module tb_decode_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_LANES = 2;
  localparam int NUM_FIELDS = 14; // word plus 13 bundle fields
  localparam int MAX_CASES = 64;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  typedef struct packed {
    logic [31:0]                   word;
    rv64_decode_pkg::decode_ctrl_t ctrl;
  } case_rec_t;

  logic                                          i_clk;
  logic                                          i_rst_n;
  logic                                          i_valid;
  logic [NUM_LANES*32-1:0]                       i_packet;
  logic                                          o_valid;
  rv64_decode_pkg::decode_ctrl_t [NUM_LANES-1:0] o_ctrl;
  logic                                          o_halt;

  logic [63:0] raw_mem [0:NUM_FIELDS*MAX_CASES-1];
  case_rec_t   case_tab [0:MAX_CASES-1];
  int          num_cases;
  int          seed = 32'h8aea_a65e;

  decode_stage_top #(.NUM_LANES(NUM_LANES)) u_decode_stage_top (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_packet (i_packet),
    .o_valid  (o_valid),
    .o_ctrl   (o_ctrl),
    .o_halt   (o_halt)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("error %s got %0h expected %0h", name, got, exp);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_lane(input int lane, input rv64_decode_pkg::decode_ctrl_t got,
                            input rv64_decode_pkg::decode_ctrl_t exp);
    string p;
    p = $sformatf("o_ctrl[%0d]", lane);
    check_value({p, ".imm"}, 128'(got.imm), 128'(exp.imm));
    check_value({p, ".ra"}, 128'(got.ra), 128'(exp.ra));
    check_value({p, ".rb"}, 128'(got.rb), 128'(exp.rb));
    check_value({p, ".rd"}, 128'(got.rd), 128'(exp.rd));
    check_value({p, ".branch"}, 128'(got.branch), 128'(exp.branch));
    check_value({p, ".alu_a_src"}, 128'(got.alu_a_src), 128'(exp.alu_a_src));
    check_value({p, ".alu_b_src"}, 128'(got.alu_b_src), 128'(exp.alu_b_src));
    check_value({p, ".alu_ctr"}, 128'(got.alu_ctr), 128'(exp.alu_ctr));
    check_value({p, ".word_cut"}, 128'(got.word_cut), 128'(exp.word_cut));
    check_value({p, ".reg_wr"}, 128'(got.reg_wr), 128'(exp.reg_wr));
    check_value({p, ".mem_to_reg"}, 128'(got.mem_to_reg), 128'(exp.mem_to_reg));
    check_value({p, ".mem_wr"}, 128'(got.mem_wr), 128'(exp.mem_wr));
    check_value({p, ".mem_op"}, 128'(got.mem_op), 128'(exp.mem_op));
  endtask

  task automatic load_cases();
    int base;
    for (int i = 0; i < NUM_FIELDS*MAX_CASES; i++) begin
      raw_mem[i] = {32'h0000_0001, i}; // wider than any word, marks empty slots
    end
    $readmemh("decode_cases.txt", raw_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && raw_mem[num_cases*NUM_FIELDS][63:32] == 32'd0) begin
      base = num_cases * NUM_FIELDS;
      case_tab[num_cases].word            = raw_mem[base][31:0];
      case_tab[num_cases].ctrl.imm        = raw_mem[base+1];
      case_tab[num_cases].ctrl.ra         = raw_mem[base+2][4:0];
      case_tab[num_cases].ctrl.rb         = raw_mem[base+3][4:0];
      case_tab[num_cases].ctrl.rd         = raw_mem[base+4][4:0];
      case_tab[num_cases].ctrl.branch     = raw_mem[base+5][2:0];
      case_tab[num_cases].ctrl.alu_a_src  = raw_mem[base+6][0];
      case_tab[num_cases].ctrl.alu_b_src  = raw_mem[base+7][1:0];
      case_tab[num_cases].ctrl.alu_ctr    = raw_mem[base+8][3:0];
      case_tab[num_cases].ctrl.word_cut   = raw_mem[base+9][0];
      case_tab[num_cases].ctrl.reg_wr     = raw_mem[base+10][0];
      case_tab[num_cases].ctrl.mem_to_reg = raw_mem[base+11][0];
      case_tab[num_cases].ctrl.mem_wr     = raw_mem[base+12][0];
      case_tab[num_cases].ctrl.mem_op     = raw_mem[base+13][2:0];
      num_cases++;
    end
  endtask

  initial begin
    int   cycle;
    int   next_case;
    int   gap;
    int   limit;
    int   head;
    int   idx;
    int   due_q[$];
    int   head_q[$];
    logic exp_halt;
    rv64_decode_pkg::decode_ctrl_t [NUM_LANES-1:0] last_ctrl;

    i_rst_n  = 1'b0;
    i_valid  = 1'b0;
    i_packet = '0;
    cycle = 0;
    next_case = 0;
    gap = 0;
    exp_halt = 1'b0;
    last_ctrl = '0;
    load_cases();
    limit = 3 * num_cases + 100;
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    check_value("o_valid", 128'(o_valid), 128'(0));
    check_value("o_halt", 128'(o_halt), 128'(0));

    while (next_case < num_cases || head_q.size() > 0) begin
      @(negedge i_clk);
      cycle++;
      if (cycle > limit) begin
        $display("timeout after %0d cycles with %0d packets still pending", cycle, head_q.size());
        $display("Errors found");
        $fatal(1, "timeout");
      end
      if (o_valid) begin
        if (head_q.size() == 0) begin
          $display("o_valid went high at cycle %0d with no packet in flight", cycle);
          $display("Errors found");
          $fatal(1, "unexpected output strobe");
        end
        check_value("o_valid cycle", 128'(cycle), 128'(due_q.pop_front()));
        head = head_q.pop_front();
        for (int l = 0; l < NUM_LANES; l++) begin
          idx = (head + l) % num_cases;
          check_lane(l, o_ctrl[l], case_tab[idx].ctrl);
          last_ctrl[l] = case_tab[idx].ctrl;
          if (case_tab[idx].word == EBREAK_WORD) begin
            exp_halt = 1'b1; // rises with this strobe
          end
        end
      end else begin
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
          $display("no o_valid at cycle %0d for the packet sent %0d cycles earlier",
                   cycle, 2);
          $display("Errors found");
          $fatal(1, "missing output strobe");
        end
        for (int l = 0; l < NUM_LANES; l++) begin
          check_lane(l, o_ctrl[l], last_ctrl[l]); // held without strobe
        end
      end
      check_value("o_halt", 128'(o_halt), 128'(exp_halt));

      if (gap > 0) begin
        i_valid = 1'b0;
        gap--;
      end else if (next_case < num_cases) begin
        for (int l = 0; l < NUM_LANES; l++) begin
          i_packet[l*32 +: 32] = case_tab[(next_case + l) % num_cases].word;
        end
        i_valid = 1'b1;
        head_q.push_back(next_case);
        due_q.push_back(cycle + 2);
        next_case += NUM_LANES;
        gap = $unsigned($random(seed)) % 3; // 0 means back-to-back
      end else begin
        i_valid = 1'b0;
      end
    end

    if (num_cases > 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("no cases could be loaded from decode_cases.txt");
      $display("Errors found");
      $fatal(1, "empty case table");
    end
  end

endmodule

//--- decode_cases.txt
// word imm ra rb rd branch alu_a_src alu_b_src alu_ctr word_cut reg_wr mem_to_reg mem_wr mem_op
// all hex, one instruction per line
00510093 0000000000000005 02 05 01 0 0 1 0 0 1 0 0 7 // addi x1,x2,5
fff20193 ffffffffffffffff 04 1f 03 0 0 1 0 0 1 0 0 7 // addi x3,x4,-1
123452b7 0000000012345000 08 03 05 0 0 1 3 0 1 0 0 7 // lui x5,0x12345
80000337 ffffffff80000000 00 00 06 0 0 1 3 0 1 0 0 7 // lui x6,0x80000
fffff397 fffffffffffff000 1f 1f 07 0 1 1 0 0 1 0 0 7 // auipc x7,0xfffff
008000ef 0000000000000008 00 08 01 1 1 2 0 0 1 0 0 7 // jal x1,8
ffdff06f fffffffffffffffc 1f 1d 00 1 1 2 0 0 1 0 0 7 // jal x0,-4
010280e7 0000000000000010 05 10 01 2 1 2 0 0 1 0 0 7 // jalr x1,16(x5)
00208863 0000000000000010 01 02 10 4 0 0 8 0 0 0 0 7 // beq x1,x2,16
fe419ce3 fffffffffffffff8 03 04 19 5 0 0 8 0 0 0 0 7 // bne x3,x4,-8
0262c063 0000000000000020 05 06 00 6 0 0 8 0 0 0 0 7 // blt x5,x6,32
0083d263 0000000000000004 07 08 04 7 0 0 8 0 0 0 0 7 // bge x7,x8,4
80a4e063 fffffffffffff000 09 0a 00 6 0 0 8 0 0 0 0 7 // bltu x9,x10,-4096
7ec5ff63 00000000000007fe 0b 0c 1e 7 0 0 8 0 0 0 0 7 // bgeu x11,x12,2046
ffe11083 fffffffffffffffe 02 1e 01 0 0 1 0 0 1 1 0 2 // lh x1,-2(x2)
00822183 0000000000000008 04 08 03 0 0 1 0 0 1 1 0 4 // lw x3,8(x4)
01033283 0000000000000010 06 10 05 0 0 1 0 0 1 1 0 6 // ld x5,16(x6)
00044383 0000000000000000 08 00 07 0 0 1 0 0 1 1 0 1 // lbu x7,0(x8)
00255483 0000000000000002 0a 02 09 0 0 1 0 0 1 1 0 3 // lhu x9,2(x10)
002081a3 0000000000000003 01 02 03 0 0 1 0 0 0 0 1 0 // sb x2,3(x1)
fe419d23 fffffffffffffffa 03 04 1a 0 0 1 0 0 0 0 1 2 // sh x4,-6(x3)
00100073 0000000000000001 00 01 00 0 0 1 e 0 1 0 0 7 // ebreak
0462a023 0000000000000040 05 06 00 0 0 1 0 0 0 0 1 4 // sw x6,64(x5)
7e83bfa3 00000000000007ff 07 08 1f 0 0 1 0 0 0 0 1 6 // sd x8,2047(x7)
003100b3 0000000000000000 02 03 01 0 0 0 0 0 1 0 0 7 // add x1,x2,x3
40628233 0000000000000000 05 06 04 0 0 0 8 0 1 0 0 7 // sub x4,x5,x6
009463b3 0000000000000000 08 09 07 0 0 0 6 0 1 0 0 7 // or x7,x8,x9
02c58533 0000000000000000 0b 0c 0a 0 0 0 c 0 1 0 0 7 // mul x10,x11,x12
02111093 0000000000000021 02 01 01 0 0 1 1 0 1 0 0 7 // slli x1,x2,33
00425193 0000000000000004 04 04 03 0 0 1 5 0 1 0 0 7 // srli x3,x4,4
00133293 0000000000000001 06 01 05 0 0 1 a 0 1 0 0 7 // sltiu x5,x6,1
fff44393 ffffffffffffffff 08 1f 07 0 0 1 4 0 1 0 0 7 // xori x7,x8,-1
0ff57493 00000000000000ff 0a 1f 09 0 0 1 7 0 1 0 0 7 // andi x9,x10,255
ffd1009b fffffffffffffffd 02 1d 01 0 0 1 0 1 1 0 0 7 // addiw x1,x2,-3
005201bb 0000000000000000 04 05 03 0 0 0 0 1 1 0 0 7 // addw x3,x4,x5
4083833b 0000000000000000 07 08 06 0 0 0 8 1 1 0 0 7 // subw x6,x7,x8
00b514bb 0000000000000000 0a 0b 09 0 0 0 1 1 1 0 0 7 // sllw x9,x10,x11
02e6863b 0000000000000000 0d 0e 0c 0 0 0 c 1 1 0 0 7 // mulw x12,x13,x14
031847bb 0000000000000000 10 11 0f 0 0 0 b 1 1 0 0 7 // divw x15,x16,x17
0349e93b 0000000000000000 13 14 12 0 0 0 d 1 1 0 0 7 // remw x18,x19,x20
00000000 0000000000000000 00 00 00 0 0 0 f 0 0 0 0 7 // all zero, unknown
ffffffff 0000000000000000 1f 1f 1f 0 0 0 f 0 0 0 0 7 // all ones, unknown

//--- src.f
rv64_decode_pkg.sv
fetch_packet_reg.sv
inst_decoder.sv
decode_out_reg.sv
decode_stage_top.sv
tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds the decode stage testbench with Verilator, runs it and scans sim.log
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_decode_stage -f src.f \
  -o sim_decode && ./obj_dir/sim_decode > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log && exit 0 || exit 1
